/* list.f */
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/execute_unit.sv
design/memory_unit.sv
design/wisc_core.sv
test/clock_gen.sv
test/wisc_core_sva.sv
test/wisc_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module wisc_core_tb \
	-o wisc_core_sim > build.log 2>&1 || echo "TEST FAILED" > sim.log
[ -f sim.log ] || ./obj_dir/wisc_core_sim > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
grep -q "TEST OK" sim.log || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

/* test/wisc_core_tb.sv */
// Testbench running random programs on the core against an instruction-level model
`timescale 1ns/1ns
`include "cpu_defines.svh"

module wisc_core_tb;

	localparam int NUM_TESTS = 8;
	localparam int MAX_LEN   = 64;

	logic              clk;
	logic              rst;
	logic              prog_we;
	isa_pkg::pc_t      prog_addr;
	isa_pkg::instr_t   prog_data;
	logic              start;
	logic              halted;
	logic              wb_valid;
	isa_pkg::reg_idx_t wb_reg;
	isa_pkg::word_t    wb_data;

	logic [31:0]       rng;
	isa_pkg::instr_t   progs [NUM_TESTS][MAX_LEN];
	int                prog_len [NUM_TESTS];
	isa_pkg::word_t    m_regs [`REG_CNT];     // Model state, kept across tests
	isa_pkg::word_t    m_mem [`DMEM_DEPTH];
	isa_pkg::reg_idx_t exp_reg [$];
	isa_pkg::word_t    exp_data [$];
	int                errors;
	int                test_errors;
	int                checks;
	int                wb_seen;
	int                cycles;
	int                cycle_limit;

	clock_gen i_clock_gen (.clk(clk), .rst(rst));

	wisc_core i_wisc_core (
		.clk(clk), .rst(rst),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.start(start), .halted(halted),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
	);

	bind wisc_core wisc_core_sva i_wisc_core_sva (
		.clk(clk), .rst(rst), .halted(halted),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
	);

	function automatic logic [31:0] rand_next();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	function automatic isa_pkg::instr_t encode(isa_pkg::opcode_t opc, int rd, int rs, int low);
		return {opc, 4'(rd), 4'(rs), 4'(low)};
	endfunction

	function automatic isa_pkg::instr_t encode_imm8(isa_pkg::opcode_t opc, int rd, int imm);
		return {opc, 4'(rd), 8'(imm)};
	endfunction

	function automatic string kind_name(int kind);
		case (kind)
			0: return "constants";
			1: return "alu";
			2: return "memory";
			3: return "branch";
			4: return "dependent";
			default: return "mixed";
		endcase
	endfunction

	function automatic isa_pkg::word_t reg_val(isa_pkg::reg_idx_t idx);
		return (idx == '0) ? 16'h0000 : m_regs[idx];   // r0 reads zero
	endfunction

	task automatic report_problem(input string msg);
		$display("%s", msg);
		errors++;
		test_errors++;
	endtask

	task automatic check_reg(input string name, input isa_pkg::reg_idx_t got,
		input isa_pkg::reg_idx_t want);
		checks++;
		if (got !== want) begin
			$display("Fail %s: got %h, expected %h", name, got, want);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_word(input string name, input isa_pkg::word_t got,
		input isa_pkg::word_t want);
		checks++;
		if (got !== want) begin
			$display("Fail %s: got %h, expected %h", name, got, want);
			errors++;
			test_errors++;
		end
	endtask

	// Program shapes follow the kind; branches only jump forward inside the program
	task automatic build_program(input int t, input int kind);
		logic [31:0] r;
		logic [3:0] opc4;
		int len;
		int prev;
		int rd;
		int sel;
		int base;
		int off;
		isa_pkg::instr_t ins;
		r = rand_next();
		len = 30 + int'(r[15:0] % 16'd11);
		prev = 1;
		base = 0;
		off = 0;
		for (int i = 0; i < len - 1; i++) begin
			r = rand_next();
			rd = 1 + int'(r[3:0] % 4'd15);
			sel = int'(r[15:0] % 16'd10);
			case (kind)
				0: begin
					if (i % 3 == 0) begin
						ins = encode_imm8(isa_pkg::OP_LLB, rd, int'(r[23:16]));
						prev = rd;
					end else if (i % 3 == 1) begin
						ins = encode_imm8(isa_pkg::OP_LHB, prev, int'(r[31:24]));
					end else begin
						ins = encode(isa_pkg::OP_ADD, int'(r[27:24]), prev, int'(r[7:4]));
					end
				end
				1: ins = encode(isa_pkg::opcode_t'(r[15:12] % 4'd7), int'(r[3:0]),
					int'(r[7:4]), int'(r[11:8]));
				2: begin
					if (i % 3 == 0) begin
						ins = encode(isa_pkg::opcode_t'(r[13:12]), rd, int'(r[7:4]),
							int'(r[11:8]));
					end else if (i % 3 == 1) begin
						base = int'(r[7:4]);
						off = int'(r[11:8]);
						ins = encode(isa_pkg::OP_SW, int'(r[19:16]), base, off);
					end else begin
						ins = encode(isa_pkg::OP_LW, rd, base, off);  // Same address as the SW
					end
				end
				3: begin
					if (i % 4 == 3) begin
						off = int'(r[31:20]) % (len - 1 - i);
						ins = encode_imm8(r[16] ? isa_pkg::OP_BRZ : isa_pkg::OP_BRN,
							int'(r[7:4]), off);
					end else if (i % 4 == 0) begin
						ins = encode_imm8(isa_pkg::OP_LLB, rd, r[24] ? 0 : int'(r[23:16]));
					end else begin
						ins = encode(isa_pkg::opcode_t'(r[13:12]), rd, int'(r[7:4]),
							int'(r[11:8]));
					end
				end
				4: begin
					if (sel < 7) begin
						ins = encode(isa_pkg::opcode_t'(4'(sel)), rd, prev, prev);
						prev = rd;
					end else if (sel == 7) begin
						ins = encode(isa_pkg::OP_LW, rd, prev, int'(r[19:16]));
						prev = rd;
					end else if (sel == 8) begin
						ins = encode_imm8(isa_pkg::OP_LHB, prev, int'(r[23:16]));
					end else begin
						ins = encode_imm8(r[24] ? isa_pkg::OP_BRZ : isa_pkg::OP_BRN, prev, 0);
					end
				end
				default: begin
					opc4 = (r[15:12] == 4'd15) ? 4'd13 : r[15:12];
					if (opc4 == 4'd11 || opc4 == 4'd12) begin
						off = int'(r[31:20]) % (len - 1 - i);
						ins = encode_imm8(isa_pkg::opcode_t'(opc4), int'(r[11:8]), off);
					end else begin
						ins = {opc4, r[27:16]};
					end
				end
			endcase
			progs[t][i] = ins;
		end
		progs[t][len-1] = {isa_pkg::OP_HLT, 12'h000};
		prog_len[t] = len;
	endtask

	task automatic retire(input int rd, input isa_pkg::word_t v);
		m_regs[rd] = v;
		exp_reg.push_back(isa_pkg::reg_idx_t'(rd));
		exp_data.push_back(v);
	endtask

	// Runs the program one instruction at a time and queues the expected writebacks
	task automatic model_program(input int t);
		int pc;
		int steps;
		int rd;
		int sh;
		logic done;
		isa_pkg::instr_t ins;
		isa_pkg::word_t a;
		isa_pkg::word_t b;
		isa_pkg::word_t d;
		isa_pkg::word_t sx4;
		isa_pkg::word_t sx8;
		isa_pkg::word_t v;
		pc = 0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < 256 && pc < prog_len[t]) begin
			ins = progs[t][pc];
			rd = int'(ins[11:8]);
			a = reg_val(ins[7:4]);
			b = reg_val(ins[3:0]);
			d = reg_val(ins[11:8]);
			sh = int'(ins[3:0]);
			sx4 = {{12{ins[3]}}, ins[3:0]};
			sx8 = {{8{ins[7]}}, ins[7:0]};
			pc = pc + 1;
			steps++;
			case (isa_pkg::opcode_t'(ins[15:12]))
				isa_pkg::OP_ADD: retire(rd, a + b);
				isa_pkg::OP_SUB: retire(rd, a - b);
				isa_pkg::OP_AND: retire(rd, a & b);
				isa_pkg::OP_NOR: retire(rd, ~(a | b));
				isa_pkg::OP_SLL: retire(rd, a << sh);
				isa_pkg::OP_SRL: retire(rd, a >> sh);
				isa_pkg::OP_SRA: retire(rd, (a >> sh) | (a[15] ? ~(16'hFFFF >> sh) : 16'h0000));
				isa_pkg::OP_LW: begin
					v = a + sx4;
					retire(rd, m_mem[v[7:0]]);
				end
				isa_pkg::OP_SW: begin
					v = a + sx4;
					m_mem[v[7:0]] = d;
				end
				isa_pkg::OP_LHB: retire(rd, {ins[7:0], d[7:0]});
				isa_pkg::OP_LLB: retire(rd, sx8);
				isa_pkg::OP_BRZ: if (d == 16'h0000) pc = pc + int'($signed(sx8));
				isa_pkg::OP_BRN: if (d != 16'h0000) pc = pc + int'($signed(sx8));
				isa_pkg::OP_HLT: done = 1'b1;
				default: done = 1'b0;   // Spare opcodes do nothing
			endcase
		end
		if (!done) begin
			report_problem($sformatf("Model of program %0d never reached HLT", t));
		end
	endtask

	task automatic run_test(input int t);
		int n_exp;
		test_errors = 0;
		wb_seen = 0;
		model_program(t);
		n_exp = exp_reg.size();
		for (int i = 0; i < prog_len[t]; i++) begin
			@(posedge clk);
			prog_we   <= 1'b1;
			prog_addr <= isa_pkg::pc_t'(i);
			prog_data <= progs[t][i];
		end
		@(posedge clk);
		prog_we <= 1'b0;
		start   <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		while (!halted) @(negedge clk);
		if (exp_reg.size() != 0) begin
			report_problem($sformatf("Core halted with %0d writebacks still missing",
				exp_reg.size()));
		end
		repeat (4) @(negedge clk);   // Any late writeback shows up here
		$display("Test %0d %s: %0d of %0d writebacks seen, %0d errors", t,
			kind_name(t % 6), wb_seen, n_exp, test_errors);
	endtask

	always @(negedge clk) begin
		if (!rst && wb_valid) begin
			wb_seen++;
			if (exp_reg.size() == 0) begin
				report_problem($sformatf("Writeback to r%0d with no result expected", wb_reg));
			end else begin
				check_reg("wb_reg", wb_reg, exp_reg.pop_front());
				check_word("wb_data", wb_data, exp_data.pop_front());
			end
		end
	end

	always @(negedge clk) begin
		if (!rst) begin
			cycles++;
			if (cycle_limit > 0 && cycles > cycle_limit) begin
				$display("Timeout, the run went past %0d cycles", cycle_limit);
				$display("TEST FAILED");
				$finish;
			end
		end
	end

	initial begin
		rng = 32'h6cfc_50d4;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		start = 1'b0;
		errors = 0;
		test_errors = 0;
		checks = 0;
		wb_seen = 0;
		cycles = 0;
		cycle_limit = 0;
		for (int i = 0; i < `REG_CNT; i++) begin
			m_regs[i] = '0;
		end
		for (int i = 0; i < `DMEM_DEPTH; i++) begin
			m_mem[i] = '0;
		end
		for (int t = 0; t < NUM_TESTS; t++) begin
			build_program(t, t % 6);
			cycle_limit += 10 * prog_len[t] + 20;
		end
		wait (rst == 1'b0);
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_test(t);
		end
		$display("Tests run: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* test/wisc_core_sva.sv */
// Bound checks on the writeback and halt outputs of the core
`timescale 1ns/1ns

module wisc_core_sva (
	input logic              clk,
	input logic              rst,
	input logic              halted,
	input logic              wb_valid,
	input isa_pkg::reg_idx_t wb_reg,
	input isa_pkg::word_t    wb_data
);

	// Outputs come out of reset quiet
	reset_quiet: assert property (@(posedge clk) rst |=> (!wb_valid && !halted))
		else $error("wb_valid or halted high in the cycle after reset");

	no_wb_when_halted: assert property (@(posedge clk) disable iff (rst)
		halted |-> !wb_valid)
		else $error("Writeback strobe while the core is halted");

	wb_known: assert property (@(posedge clk) disable iff (rst)
		wb_valid |-> !$isunknown({wb_reg, wb_data}))
		else $error("Writeback register or data unknown while wb_valid is high");

endmodule

/* test/clock_gen.sv */
// Testbench clock and power-on reset source for the core
`timescale 1ns/1ns

module clock_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;   // 20 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* design/wisc_core.sv */
// Top level of the five-stage 16-bit core, wiring fetch, decode, execute and memory
`timescale 1ns/1ns

module wisc_core (
	input  logic              clk,
	input  logic              rst,
	input  logic              prog_we,
	input  isa_pkg::pc_t      prog_addr,
	input  isa_pkg::instr_t   prog_data,
	input  logic              start,
	output logic              halted,
	output logic              wb_valid,
	output isa_pkg::reg_idx_t wb_reg,
	output isa_pkg::word_t    wb_data
);

	// IF/ID
	logic              if_valid;
	isa_pkg::instr_t   if_instr;
	isa_pkg::pc_t      if_pc;
	logic              stall;

	// ID/EX
	logic              id_valid;
	pipe_pkg::alu_op_t id_op;
	isa_pkg::word_t    id_a;
	isa_pkg::word_t    id_b;
	isa_pkg::word_t    id_store;
	isa_pkg::word_t    id_imm;
	logic              id_we;
	isa_pkg::reg_idx_t id_rd;
	logic              id_load;
	logic              id_store_en;
	logic              id_halt;
	logic              id_brz;
	logic              id_brn;
	isa_pkg::pc_t      id_pc;

	// EX/MEM and branch redirect
	logic              ex_valid;
	logic              ex_we;
	isa_pkg::reg_idx_t ex_rd;
	isa_pkg::word_t    ex_result;
	isa_pkg::daddr_t   ex_addr;
	logic              ex_load;
	logic              ex_store_en;
	isa_pkg::word_t    ex_store;
	logic              ex_halt;
	logic              redirect;
	isa_pkg::pc_t      redirect_pc;

	logic              wb_halt;

	fetch_unit i_fetch_unit (
		.clk(clk), .rst(rst),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.start(start), .stall(stall),
		.redirect(redirect), .redirect_pc(redirect_pc), .wb_halt(wb_halt),
		.if_valid(if_valid), .if_instr(if_instr), .if_pc(if_pc), .halted(halted)
	);

	decode_unit i_decode_unit (
		.clk(clk), .rst(rst),
		.if_valid(if_valid), .if_instr(if_instr), .if_pc(if_pc), .redirect(redirect),
		.ex_valid(ex_valid), .ex_we(ex_we), .ex_rd(ex_rd),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
		.id_valid(id_valid), .id_op(id_op), .id_a(id_a), .id_b(id_b),
		.id_store(id_store), .id_imm(id_imm), .id_we(id_we), .id_rd(id_rd),
		.id_load(id_load), .id_store_en(id_store_en), .id_halt(id_halt),
		.id_brz(id_brz), .id_brn(id_brn), .id_pc(id_pc), .stall(stall)
	);

	execute_unit i_execute_unit (
		.clk(clk), .rst(rst),
		.id_valid(id_valid), .id_op(id_op), .id_a(id_a), .id_b(id_b),
		.id_store(id_store), .id_imm(id_imm), .id_we(id_we), .id_rd(id_rd),
		.id_load(id_load), .id_store_en(id_store_en), .id_halt(id_halt),
		.id_brz(id_brz), .id_brn(id_brn), .id_pc(id_pc),
		.ex_valid(ex_valid), .ex_we(ex_we), .ex_rd(ex_rd), .ex_result(ex_result),
		.ex_addr(ex_addr), .ex_load(ex_load), .ex_store_en(ex_store_en),
		.ex_store(ex_store), .ex_halt(ex_halt),
		.redirect(redirect), .redirect_pc(redirect_pc)
	);

	memory_unit i_memory_unit (
		.clk(clk), .rst(rst),
		.ex_valid(ex_valid), .ex_we(ex_we), .ex_rd(ex_rd), .ex_result(ex_result),
		.ex_addr(ex_addr), .ex_load(ex_load), .ex_store_en(ex_store_en),
		.ex_store(ex_store), .ex_halt(ex_halt),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .wb_halt(wb_halt)
	);

endmodule

/* design/memory_unit.sv */
// Memory stage: on-chip data memory, writeback select and MEM/WB register
`timescale 1ns/1ns
`include "cpu_defines.svh"

module memory_unit (
	input  logic              clk,
	input  logic              rst,
	input  logic              ex_valid,
	input  logic              ex_we,
	input  isa_pkg::reg_idx_t ex_rd,
	input  isa_pkg::word_t    ex_result,
	input  isa_pkg::daddr_t   ex_addr,
	input  logic              ex_load,
	input  logic              ex_store_en,
	input  isa_pkg::word_t    ex_store,
	input  logic              ex_halt,
	output logic              wb_valid,
	output isa_pkg::reg_idx_t wb_reg,
	output isa_pkg::word_t    wb_data,
	output logic              wb_halt
);

	isa_pkg::word_t dmem [`DMEM_DEPTH];
	isa_pkg::word_t load_data;

	assign load_data = dmem[ex_addr];  // Asynchronous read

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `DMEM_DEPTH; i++) begin
				dmem[i] <= '0;
			end
		end else if (ex_valid && ex_store_en) begin
			dmem[ex_addr] <= ex_store;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
			wb_halt  <= 1'b0;
		end else begin
			wb_valid <= ex_valid && ex_we;
			wb_halt  <= ex_valid && ex_halt;  // HLT has retired
		end
	end

	always_ff @(posedge clk) begin
		wb_reg  <= ex_rd;
		wb_data <= ex_load ? load_data : ex_result;
	end

endmodule

/* design/execute_unit.sv */
// Execute stage: ALU, immediate byte loads, branch resolution and EX/MEM register
`timescale 1ns/1ns
`include "cpu_defines.svh"

module execute_unit (
	input  logic              clk,
	input  logic              rst,
	input  logic              id_valid,
	input  pipe_pkg::alu_op_t id_op,
	input  isa_pkg::word_t    id_a,
	input  isa_pkg::word_t    id_b,
	input  isa_pkg::word_t    id_store,
	input  isa_pkg::word_t    id_imm,
	input  logic              id_we,
	input  isa_pkg::reg_idx_t id_rd,
	input  logic              id_load,
	input  logic              id_store_en,
	input  logic              id_halt,
	input  logic              id_brz,
	input  logic              id_brn,
	input  isa_pkg::pc_t      id_pc,
	output logic              ex_valid,
	output logic              ex_we,
	output isa_pkg::reg_idx_t ex_rd,
	output isa_pkg::word_t    ex_result,
	output isa_pkg::daddr_t   ex_addr,
	output logic              ex_load,
	output logic              ex_store_en,
	output isa_pkg::word_t    ex_store,
	output logic              ex_halt,
	output logic              redirect,
	output isa_pkg::pc_t      redirect_pc
);

	isa_pkg::word_t alu_res;
	logic op_zero;

	always_comb begin
		case (id_op)
			pipe_pkg::ALU_ADD: alu_res = id_a + id_b;
			pipe_pkg::ALU_SUB: alu_res = id_a - id_b;
			pipe_pkg::ALU_AND: alu_res = id_a & id_b;
			pipe_pkg::ALU_NOR: alu_res = ~(id_a | id_b);
			pipe_pkg::ALU_SLL: alu_res = id_a << id_b[3:0];
			pipe_pkg::ALU_SRL: alu_res = id_a >> id_b[3:0];
			pipe_pkg::ALU_SRA: alu_res = isa_pkg::word_t'($signed(id_a) >>> id_b[3:0]);
			default: alu_res = id_imm | (id_store & id_b);  // LLB, or LHB merged with old rd
		endcase
	end

	// Branch operand is the rd value carried on id_store
	assign op_zero     = (id_store == '0);
	assign redirect    = id_valid && ((id_brz && op_zero) || (id_brn && !op_zero));
	assign redirect_pc = id_pc + 1'b1 + id_imm[`PC_W-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid    <= 1'b0;
			ex_we       <= 1'b0;
			ex_load     <= 1'b0;
			ex_store_en <= 1'b0;
			ex_halt     <= 1'b0;
		end else begin
			ex_valid    <= id_valid;
			ex_we       <= id_we;
			ex_load     <= id_load;
			ex_store_en <= id_store_en;
			ex_halt     <= id_halt;
		end
	end

	always_ff @(posedge clk) begin
		ex_rd     <= id_rd;
		ex_result <= alu_res;
		ex_addr   <= alu_res[`DADDR_W-1:0];  // Address wraps to the memory size
		ex_store  <= id_store;
	end

endmodule

/* design/decode_unit.sv */
// Decode stage: control decode, register file, load-use stalls and ID/EX register
`timescale 1ns/1ns
`include "cpu_defines.svh"

module decode_unit (
	input  logic              clk,
	input  logic              rst,
	input  logic              if_valid,
	input  isa_pkg::instr_t   if_instr,
	input  isa_pkg::pc_t      if_pc,
	input  logic              redirect,
	input  logic              ex_valid,
	input  logic              ex_we,
	input  isa_pkg::reg_idx_t ex_rd,
	input  logic              wb_valid,
	input  isa_pkg::reg_idx_t wb_reg,
	input  isa_pkg::word_t    wb_data,
	output logic              id_valid,
	output pipe_pkg::alu_op_t id_op,
	output isa_pkg::word_t    id_a,
	output isa_pkg::word_t    id_b,
	output isa_pkg::word_t    id_store,
	output isa_pkg::word_t    id_imm,
	output logic              id_we,
	output isa_pkg::reg_idx_t id_rd,
	output logic              id_load,
	output logic              id_store_en,
	output logic              id_halt,
	output logic              id_brz,
	output logic              id_brn,
	output isa_pkg::pc_t      id_pc,
	output logic              stall
);

	isa_pkg::word_t rf [`REG_CNT];
	isa_pkg::opcode_t opc;
	isa_pkg::reg_idx_t rd;
	isa_pkg::reg_idx_t rs;
	isa_pkg::reg_idx_t rt;
	isa_pkg::reg_idx_t rb;
	isa_pkg::word_t rdata_a;
	isa_pkg::word_t rdata_b;
	isa_pkg::word_t b_val;
	isa_pkg::word_t imm_val;
	isa_pkg::word_t sext4;
	isa_pkg::word_t sext8;
	pipe_pkg::alu_op_t op;
	logic we;
	logic load;
	logic store_en;
	logic halt;
	logic brz;
	logic brn;
	logic use_a;
	logic use_b;
	logic advance;

	assign opc   = isa_pkg::opcode_t'(if_instr[15:12]);
	assign rd    = if_instr[11:8];
	assign rs    = if_instr[7:4];
	assign rt    = if_instr[3:0];
	assign rb    = (if_instr[15:14] == 2'b00) ? rt : rd;  // Reg-reg ops read rt, others rd
	assign sext4 = {{(`WORD_W-4){if_instr[3]}}, if_instr[3:0]};
	assign sext8 = {{(`WORD_W-8){if_instr[7]}}, if_instr[7:0]};

	// r0 reads zero, writeback bypasses the array
	function automatic isa_pkg::word_t rf_read(isa_pkg::reg_idx_t idx);
		isa_pkg::word_t val;
		if (idx == '0) begin
			val = '0;
		end else if (wb_valid && wb_reg == idx) begin
			val = wb_data;
		end else begin
			val = rf[idx];
		end
		return val;
	endfunction

	// Destination still in flight in ID/EX or EX/MEM
	function automatic logic pending(isa_pkg::reg_idx_t idx);
		return (id_valid && id_we && id_rd == idx) || (ex_valid && ex_we && ex_rd == idx);
	endfunction

	always_comb begin
		rdata_a = rf_read(rs);
		rdata_b = rf_read(rb);
	end

	always_comb begin
		op       = pipe_pkg::ALU_PASS;
		we       = 1'b0;
		load     = 1'b0;
		store_en = 1'b0;
		halt     = 1'b0;
		brz      = 1'b0;
		brn      = 1'b0;
		use_a    = 1'b0;
		use_b    = 1'b0;
		b_val    = '0;
		imm_val  = '0;
		case (opc)
			isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_NOR: begin
				op    = pipe_pkg::alu_op_t'(if_instr[14:12]);
				we    = 1'b1;
				use_a = 1'b1;
				use_b = 1'b1;
				b_val = rdata_b;
			end
			isa_pkg::OP_SLL, isa_pkg::OP_SRL, isa_pkg::OP_SRA: begin
				op    = pipe_pkg::alu_op_t'(if_instr[14:12]);
				we    = 1'b1;
				use_a = 1'b1;
				b_val = isa_pkg::word_t'(if_instr[3:0]);  // Shift amount
			end
			isa_pkg::OP_LW: begin
				op    = pipe_pkg::ALU_ADD;
				we    = 1'b1;
				load  = 1'b1;
				use_a = 1'b1;
				b_val = sext4;
			end
			isa_pkg::OP_SW: begin
				op       = pipe_pkg::ALU_ADD;
				store_en = 1'b1;
				use_a    = 1'b1;
				use_b    = 1'b1;   // Store data comes from rd
				b_val    = sext4;
			end
			isa_pkg::OP_LHB: begin
				we      = 1'b1;
				use_b   = 1'b1;
				b_val   = isa_pkg::word_t'(8'hFF);           // Keep low byte of rd
				imm_val = {if_instr[7:0], {(`WORD_W-8){1'b0}}};
			end
			isa_pkg::OP_LLB: begin
				we      = 1'b1;
				imm_val = sext8;
			end
			isa_pkg::OP_BRZ: begin
				brz     = 1'b1;
				use_b   = 1'b1;
				imm_val = sext8;
			end
			isa_pkg::OP_BRN: begin
				brn     = 1'b1;
				use_b   = 1'b1;
				imm_val = sext8;
			end
			isa_pkg::OP_HLT: halt = 1'b1;
			default: op = pipe_pkg::ALU_PASS;
		endcase
	end

	always_comb begin
		stall = if_valid && ((use_a && rs != '0 && pending(rs)) ||
			(use_b && rb != '0 && pending(rb)));
	end

	assign advance = if_valid && !stall && !redirect;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_CNT; i++) begin
				rf[i] <= '0;
			end
		end else if (wb_valid) begin
			rf[wb_reg] <= wb_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			id_valid    <= 1'b0;
			id_we       <= 1'b0;
			id_load     <= 1'b0;
			id_store_en <= 1'b0;
			id_halt     <= 1'b0;
			id_brz      <= 1'b0;
			id_brn      <= 1'b0;
		end else begin
			id_valid    <= advance;   // Bubble on stall or flush
			id_we       <= advance && we;
			id_load     <= advance && load;
			id_store_en <= advance && store_en;
			id_halt     <= advance && halt;
			id_brz      <= advance && brz;
			id_brn      <= advance && brn;
		end
	end

	always_ff @(posedge clk) begin
		id_op    <= op;
		id_a     <= rdata_a;
		id_b     <= b_val;
		id_store <= rdata_b;
		id_imm   <= imm_val;
		id_rd    <= rd;
		id_pc    <= if_pc;
	end

endmodule

/* design/fetch_unit.sv */
// Fetch stage: program-loaded instruction memory, PC, run control and IF/ID register
`timescale 1ns/1ns
`include "cpu_defines.svh"

module fetch_unit (
	input  logic            clk,
	input  logic            rst,
	input  logic            prog_we,
	input  isa_pkg::pc_t    prog_addr,
	input  isa_pkg::instr_t prog_data,
	input  logic            start,
	input  logic            stall,
	input  logic            redirect,
	input  isa_pkg::pc_t    redirect_pc,
	input  logic            wb_halt,
	output logic            if_valid,
	output isa_pkg::instr_t if_instr,
	output isa_pkg::pc_t    if_pc,
	output logic            halted
);

	isa_pkg::instr_t imem [`IMEM_DEPTH];
	isa_pkg::pc_t pc;
	pipe_pkg::run_state_t state;
	isa_pkg::instr_t fetch_word;
	logic fetch_hlt;
	logic can_start;

	assign fetch_word = imem[pc];
	assign fetch_hlt  = isa_pkg::opcode_t'(fetch_word[15:12]) == isa_pkg::OP_HLT;
	assign can_start  = start && (state == pipe_pkg::ST_IDLE || state == pipe_pkg::ST_HALTED);
	assign halted     = (state == pipe_pkg::ST_HALTED);

	always_ff @(posedge clk) begin
		if (prog_we) begin
			imem[prog_addr] <= prog_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= pipe_pkg::ST_IDLE;
			pc       <= '0;
			if_valid <= 1'b0;
		end else if (can_start) begin
			state    <= pipe_pkg::ST_RUN;
			pc       <= '0;
			if_valid <= 1'b0;
		end else if (redirect) begin
			pc       <= redirect_pc;
			if_valid <= 1'b0;        // Drop the wrong-path word
			if (state == pipe_pkg::ST_DRAIN) begin
				state <= pipe_pkg::ST_RUN;  // Flushed HLT was on the wrong path
			end
		end else if (stall) begin
			pc       <= pc;           // Hold PC and IF/ID
		end else if (state == pipe_pkg::ST_RUN) begin
			pc       <= pc + 1'b1;
			if_valid <= 1'b1;
			if (fetch_hlt) begin
				state <= pipe_pkg::ST_DRAIN;
			end
		end else begin
			if_valid <= 1'b0;
			if (state == pipe_pkg::ST_DRAIN && wb_halt) begin
				state <= pipe_pkg::ST_HALTED;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			if_instr <= fetch_word;
			if_pc    <= pc;
		end
	end

endmodule

/* design/pipe_pkg.sv */
// Pipeline control types: ALU operation select and fetch run state
package pipe_pkg;

	// Encodings 0..6 line up with opcodes ADD..SRA
	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_AND  = 3'd2,
		ALU_NOR  = 3'd3,
		ALU_SLL  = 3'd4,
		ALU_SRL  = 3'd5,
		ALU_SRA  = 3'd6,
		ALU_PASS = 3'd7    // Immediate loads
	} alu_op_t;

	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_RUN    = 2'd1,
		ST_DRAIN  = 2'd2,  // HLT fetched, waiting for it to retire
		ST_HALTED = 2'd3
	} run_state_t;

endpackage

/* design/isa_pkg.sv */
// Instruction-set types shared by the core stages and the testbench
`include "cpu_defines.svh"

package isa_pkg;

	typedef logic [`WORD_W-1:0] word_t;            // Register and memory data
	typedef logic [`WORD_W-1:0] instr_t;           // Raw instruction word
	typedef logic [$clog2(`REG_CNT)-1:0] reg_idx_t;
	typedef logic [`PC_W-1:0] pc_t;                // Instruction memory address
	typedef logic [`DADDR_W-1:0] daddr_t;          // Data memory address

	// Opcode field, bits 15..12
	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_NOR  = 4'd3,
		OP_SLL  = 4'd4,
		OP_SRL  = 4'd5,
		OP_SRA  = 4'd6,
		OP_LW   = 4'd7,
		OP_SW   = 4'd8,
		OP_LHB  = 4'd9,
		OP_LLB  = 4'd10,
		OP_BRZ  = 4'd11,
		OP_BRN  = 4'd12,
		OP_NOPD = 4'd13,   // Spare, no-op
		OP_NOPE = 4'd14,   // Spare, no-op
		OP_HLT  = 4'd15
	} opcode_t;

endpackage

/* design/cpu_defines.svh */
// Core-wide widths and memory depths for the 16-bit pipelined core
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath width
`define WORD_W 16

// Architectural register count
`define REG_CNT 16

// Instruction address width, one word per address
`define PC_W 8

// On-chip memory depths
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

// Data memory address width
`define DADDR_W 8

`endif
